// ==== src.f ====
+incdir+include
src/hackIsaPkg.sv
src/hackMemMapPkg.sv
src/hackControl.sv
src/hackAlu.sv
src/hackRegisters.sv
src/hackPc.sv
src/hackMemory.sv
src/hackRom.sv
src/hackComputer.sv
dv/hackComputer_checker.sv
dv/hackComputerTb.sv

// ==== include/hackOpcodes.svh ====
// Hack comp, dest and jump field encodings plus a C-instruction builder macro
`ifndef HACK_OPCODES_SVH
`define HACK_OPCODES_SVH

`define HACK_COMP_ZERO    7'b0101010 // 0
`define HACK_COMP_ONE     7'b0111111 // 1
`define HACK_COMP_D       7'b0001100 // D
`define HACK_COMP_A       7'b0110000 // A
`define HACK_COMP_M       7'b1110000 // M, a bit set
`define HACK_COMP_D_PLUS_A  7'b0000010 // D+A
`define HACK_COMP_D_MINUS_A 7'b0010011 // D-A
`define HACK_COMP_D_PLUS_M  7'b1000010 // D+M
`define HACK_COMP_D_AND_A   7'b0000000 // D&A
`define HACK_COMP_D_OR_A    7'b0010101 // D|A
`define HACK_COMP_NOT_D     7'b0001101 // !D

`define HACK_DEST_NONE 3'b000
`define HACK_DEST_M    3'b001
`define HACK_DEST_D    3'b010
`define HACK_DEST_A    3'b100
`define HACK_JMP_NONE  3'b000
`define HACK_JMP_GT    3'b001
`define HACK_JMP_EQ    3'b010
`define HACK_JMP_LT    3'b100
`define HACK_JMP_ALL   3'b111

// Full C-instruction word from its three fields
`define HACK_CINSTR(comp, dest, jmp) {3'b111, (comp), (dest), (jmp)}

`endif

// ==== dv/hackComputerTb.sv ====
// Testbench with run-time Hack program assembly, a reference model, ROM loading and assertion checks
`timescale 1ns/1ps
`default_nettype none

`include "hackOpcodes.svh"

module hackComputerTb;

    localparam int progMax     = 128; // Longest program plus halt loop
    localparam int resetCycles = 3;

    logic                              clk = 1'b0;
    logic                              rstN;
    logic [hackIsaPkg::wordW-1:0]      kbd;
    logic [hackMemMapPkg::screenW-1:0] scrAddr;
    logic [hackIsaPkg::wordW-1:0]      scrData;
    logic                              progWe;
    logic [hackMemMapPkg::pcW-1:0]     progAddr;
    logic [hackIsaPkg::wordW-1:0]      progData;
    logic [hackMemMapPkg::pcW-1:0]     pc;
    logic [hackMemMapPkg::addrW-1:0]   addressM;
    logic [hackIsaPkg::wordW-1:0]      outM;
    logic                              writeM;

    // Program image and expectations per ROM address
    logic [hackIsaPkg::wordW-1:0]    prog    [0:progMax-1];
    logic                            expWr   [0:progMax-1];
    logic [hackIsaPkg::wordW-1:0]    expOut  [0:progMax-1];
    logic [hackMemMapPkg::addrW-1:0] expAddr [0:progMax-1]; // A before the instruction
    logic [hackMemMapPkg::pcW-1:0]   expNext [0:progMax-1];

    logic [hackIsaPkg::wordW-1:0] refA;
    logic [hackIsaPkg::wordW-1:0] refD;
    logic [hackIsaPkg::wordW-1:0] refMem [int]; // Sparse model of data memory
    int refPc;    // Next address the model executes
    int progLen;
    string testName = "none";

    logic running = 1'b0; // Live between reset release and halt
    logic scrCheck = 1'b0;
    logic [hackIsaPkg::wordW-1:0] expScr = '0;
    int cycleCount = 0;
    int cycleLimit = 2 * resetCycles;

    logic                            expWrNow;
    logic [hackIsaPkg::wordW-1:0]    expOutNow;
    logic [hackMemMapPkg::addrW-1:0] expAddrNow;
    logic [hackMemMapPkg::pcW-1:0]   expNextNow;
    logic [hackMemMapPkg::pcW-1:0]   prevNext; // Expected pc for this cycle

    hackComputer dut0 (.clk(clk), .rstN(rstN), .kbd(kbd), .scrAddr(scrAddr), .scrData(scrData),
        .progWe(progWe), .progAddr(progAddr), .progData(progData), .pc(pc),
        .addressM(addressM), .outM(outM), .writeM(writeM));

    always #5 clk = ~clk; // 10 ns period

    assign expWrNow   = expWr[pc];
    assign expOutNow  = expOut[pc];
    assign expAddrNow = expAddr[pc];
    assign expNextNow = expNext[pc];

    always @(posedge clk) prevNext <= expNextNow;

    task automatic reportMismatch(input string what, input logic [15:0] expVal,
                                  input logic [15:0] actVal);
        $display("CHECK FAILED test=%s %s expected=%h actual=%h", testName, what, expVal, actVal);
        $display("Simulation FAILED");
        $fatal(1, "value mismatch");
    endtask

    startOk: assert property (@(posedge clk) $rose(running) |-> pc == '0)
        else reportMismatch("first pc", 16'd0, 16'($sampled(pc)));
    writeOk: assert property (@(posedge clk) disable iff (!running) writeM == expWrNow)
        else reportMismatch("writeM", 16'($sampled(expWrNow)), 16'($sampled(writeM)));
    outOk: assert property (@(posedge clk) disable iff (!running) expWrNow |-> outM == expOutNow)
        else reportMismatch("outM", $sampled(expOutNow), $sampled(outM));
    addrOk: assert property (@(posedge clk) disable iff (!running) addressM == expAddrNow)
        else reportMismatch("addressM", 16'($sampled(expAddrNow)), 16'($sampled(addressM)));
    nextOk: assert property (@(posedge clk) disable iff (!running) 1'b1 |=> pc == prevNext)
        else reportMismatch("pc", 16'($sampled(prevNext)), 16'($sampled(pc)));
    scrOk: assert property (@(posedge clk) disable iff (!scrCheck) scrData == expScr)
        else reportMismatch("scrData", $sampled(expScr), $sampled(scrData));

    // Comp field meaning from the Hack instruction table
    function automatic logic [15:0] compute(input logic [6:0] comp, input logic [15:0] d,
                                            input logic [15:0] a, input logic [15:0] m);
        case (comp)
            `HACK_COMP_ZERO:      return 16'd0;
            `HACK_COMP_ONE:       return 16'd1;
            `HACK_COMP_D:         return d;
            `HACK_COMP_A:         return a;
            `HACK_COMP_M:         return m;
            `HACK_COMP_D_PLUS_A:  return d + a;
            `HACK_COMP_D_MINUS_A: return d - a;
            `HACK_COMP_D_PLUS_M:  return d + m;
            `HACK_COMP_D_AND_A:   return d & a;
            `HACK_COMP_D_OR_A:    return d | a;
            `HACK_COMP_NOT_D:     return ~d;
            default:              return 'x; // Not used by these programs
        endcase
    endfunction

    function automatic logic [15:0] readMem(input logic [14:0] addr);
        if (addr >= hackMemMapPkg::kbdAddr) return kbd; // Keyboard word
        if (refMem.exists(int'(addr))) return refMem[int'(addr)];
        return 'x;
    endfunction

    // Append one word; model it if execution actually reaches it
    task automatic emit(input logic [15:0] word);
        logic [15:0] res;
        logic taken;
        prog[progLen] = word;
        if (progLen == refPc) begin
            expAddr[progLen] = refA[14:0];
            expWr[progLen] = 1'b0;
            expNext[progLen] = 15'(progLen + 1);
            if (!word[hackIsaPkg::cBit]) begin
                refA = word; // @value
            end else begin
                res = compute(word[hackIsaPkg::aBit:hackIsaPkg::compLo], refD, refA,
                              readMem(refA[14:0]));
                taken = (word[hackIsaPkg::jmpLt] & res[15]) |
                        (word[hackIsaPkg::jmpEq] & (res == 16'd0)) |
                        (word[hackIsaPkg::jmpGt] & !res[15] & (res != 16'd0));
                if (word[hackIsaPkg::destM]) begin
                    expWr[progLen] = 1'b1;
                    expOut[progLen] = res;
                    if (refA[14:0] < hackMemMapPkg::kbdAddr) refMem[int'(refA[14:0])] = res;
                end
                if (taken) expNext[progLen] = refA[14:0]; // Target is the old A
                if (word[hackIsaPkg::destD]) refD = res;
                if (word[hackIsaPkg::destA]) refA = res;
            end
            refPc = expNext[progLen];
        end
        progLen++;
    endtask

    task automatic emitA(input logic [14:0] v);
        emit({1'b0, v});
    endtask

    task automatic emitC(input logic [6:0] comp, input logic [2:0] dest, input logic [2:0] jmp);
        emit(`HACK_CINSTR(comp, dest, jmp));
    endtask

    task automatic newProgram(input string name);
        testName = name;
        progLen = 0;
        refPc = 0;
        refA = '0; // Registers come out of reset at zero
        refD = '0;
    endtask

    // Add the halt loop, load during reset, run until the loop is reached
    task automatic runProgram();
        int haltPc;
        haltPc = progLen;
        emitA(15'(haltPc));
        emitC(`HACK_COMP_ZERO, `HACK_DEST_NONE, `HACK_JMP_ALL);
        cycleLimit += 2 * (2 * progLen + resetCycles + 2); // Twice the load and run cycles
        rstN = 1'b0;
        for (int i = 0; i < progLen; i++) begin
            progWe = 1'b1;
            progAddr = 15'(i);
            progData = prog[i];
            @(negedge clk);
        end
        progWe = 1'b0;
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        running = 1'b1;
        while (pc != 15'(haltPc + 1)) @(negedge clk);
        @(negedge clk); // Last pc step still checked
        running = 1'b0;
    endtask

    task automatic aluProgram();
        logic [6:0] ops [5] = '{`HACK_COMP_D_PLUS_A, `HACK_COMP_D_MINUS_A, `HACK_COMP_D_AND_A,
                                `HACK_COMP_D_OR_A, `HACK_COMP_NOT_D};
        newProgram("alu");
        foreach (ops[i]) begin
            emitA(15'($urandom)); // x
            emitC(`HACK_COMP_A, `HACK_DEST_D, `HACK_JMP_NONE);
            emitA(15'($urandom)); // y, store address
            emitC(ops[i], `HACK_DEST_M, `HACK_JMP_NONE);
        end
        runProgram();
    endtask

    task automatic jumpProgram();
        logic [2:0] conds [3] = '{`HACK_JMP_LT, `HACK_JMP_EQ, `HACK_JMP_GT};
        logic [14:0] v;
        newProgram("jump");
        foreach (conds[c]) begin
            for (int s = 0; s < 3; s++) begin // Negative, zero, positive D
                v = (s == 1) ? 15'd0 : 15'($urandom % 32767 + 1);
                emitA(v);
                emitC(`HACK_COMP_A, `HACK_DEST_D, `HACK_JMP_NONE);
                if (s == 0) emitC(`HACK_COMP_NOT_D, `HACK_DEST_D, `HACK_JMP_NONE);
                emitA(15'(progLen + 3)); // Lands past the skip slot
                emitC(`HACK_COMP_D, `HACK_DEST_NONE, conds[c]);
                emitC(`HACK_COMP_ONE, `HACK_DEST_D, `HACK_JMP_NONE); // Skip slot
            end
        end
        emitA(15'(progLen + 3));
        emitC(`HACK_COMP_ZERO, `HACK_DEST_NONE, `HACK_JMP_ALL);
        emitC(`HACK_COMP_ONE, `HACK_DEST_D, `HACK_JMP_NONE);
        runProgram();
    endtask

    task automatic memMapProgram();
        logic [12:0] k;
        logic [14:0] v;
        logic [14:0] x;
        logic [14:0] r;
        k = 13'($urandom);
        v = 15'($urandom);
        x = 15'($urandom);
        r = {1'b0, 14'($urandom)}; // Inside the RAM
        kbd = 16'($urandom);
        newProgram("memmap");
        emitA(v);
        emitC(`HACK_COMP_A, `HACK_DEST_D, `HACK_JMP_NONE);
        emitA(15'(hackMemMapPkg::screenBase + k));
        emitC(`HACK_COMP_D, `HACK_DEST_M, `HACK_JMP_NONE);
        emitA(x);
        emitC(`HACK_COMP_A, `HACK_DEST_D, `HACK_JMP_NONE);
        emitA(15'(hackMemMapPkg::kbdAddr));
        emitC(`HACK_COMP_D, `HACK_DEST_M, `HACK_JMP_NONE); // Dropped by the decode
        emitA(15'(hackMemMapPkg::kbdAddr));
        emitC(`HACK_COMP_M, `HACK_DEST_D, `HACK_JMP_NONE);
        emitA(r);
        emitC(`HACK_COMP_D, `HACK_DEST_M, `HACK_JMP_NONE);
        emitA(x);
        emitC(`HACK_COMP_A, `HACK_DEST_D, `HACK_JMP_NONE);
        emitA(r);
        emitC(`HACK_COMP_D_PLUS_M, `HACK_DEST_M, `HACK_JMP_NONE); // kbd + x
        runProgram();
        scrAddr = k; // Display port sees the stored word
        expScr = {1'b0, v};
        scrCheck = 1'b1;
        @(negedge clk);
        scrCheck = 1'b0;
    endtask

    always @(negedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout in test %s after %0d cycles, halt loop never reached",
                     testName, cycleCount);
            $display("Simulation FAILED");
            $fatal(1, "cycle limit reached");
        end else if (dut0.checker0.errCount != 0) begin
            $display("A bound checker assertion failed during test %s", testName);
            $display("Simulation FAILED");
            $fatal(1, "checker failure");
        end
    end

    initial begin
        void'($urandom(32'h59f4_eed0));
        rstN = 1'b0;
        kbd = '0;
        scrAddr = '0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        repeat (resetCycles) @(negedge clk);
        aluProgram();
        jumpProgram();
        memMapProgram();
        @(negedge clk);
        if (dut0.checker0.errCount == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "checker failure at end of run");
        end
    end

endmodule

`default_nettype wire

// ==== dv/hackComputer_checker.sv ====
// Bound assertions on reset state, stores during A-instructions and PC sequencing
`timescale 1ns/1ps
`default_nettype none

module hackComputerChecker (
    input wire                          clk,
    input wire                          rstN,
    input wire [hackMemMapPkg::pcW-1:0] pc,
    input wire [hackIsaPkg::wordW-1:0]  instr,  // Fetched word
    input wire                          writeM,
    input wire                          pcLoad  // Jump taken this cycle
);

    int errCount = 0; // Polled by the testbench

    // Held in reset, fetch stays at word 0 with no store
    resetState: assert property (@(posedge clk) !rstN |-> (pc == '0 && !writeM))
        else begin
            errCount++;
            $error("pc not zero or writeM high while in reset");
        end

    // No jump means the next word in sequence
    pcStep: assert property (@(posedge clk) disable iff (!rstN)
        !pcLoad |=> pc == $past(pc) + 1'b1)
        else begin
            errCount++;
            $error("pc did not advance by one without a jump");
        end

    // An @value never stores to memory
    noStoreOnA: assert property (@(posedge clk) !instr[hackIsaPkg::cBit] |-> !writeM)
        else begin
            errCount++;
            $error("writeM high during an A-instruction");
        end

endmodule

bind hackComputer hackComputerChecker checker0 (.clk(clk), .rstN(rstN), .pc(pc),
    .instr(instr), .writeM(writeM), .pcLoad(pcLoad));

`default_nettype wire

// ==== src/hackComputer.sv ====
// Hack computer top: control, ALU, A and D registers, PC, data memory and instruction ROM
`timescale 1ns/1ps
`default_nettype none

module hackComputer (
    input  wire                              clk,
    input  wire                              rstN,
    input  wire [hackIsaPkg::wordW-1:0]      kbd,
    input  wire [hackMemMapPkg::screenW-1:0] scrAddr,
    output logic [hackIsaPkg::wordW-1:0]     scrData,
    input  wire                              progWe,
    input  wire [hackMemMapPkg::pcW-1:0]     progAddr,
    input  wire [hackIsaPkg::wordW-1:0]      progData,
    output logic [hackMemMapPkg::pcW-1:0]    pc,
    output logic [hackMemMapPkg::addrW-1:0]  addressM,
    output logic [hackIsaPkg::wordW-1:0]     outM,
    output logic                             writeM
);

    logic [hackIsaPkg::wordW-1:0] instr;
    logic [hackIsaPkg::wordW-1:0] aluOut;
    logic [hackIsaPkg::wordW-1:0] inM;
    logic [hackIsaPkg::wordW-1:0] aVal;
    logic [hackIsaPkg::wordW-1:0] dVal;
    logic [hackIsaPkg::wordW-1:0] y;    // A or M operand
    logic [hackIsaPkg::compW-1:0] aluCtl;
    logic zr;
    logic ng;
    logic aLoad;
    logic dLoad;
    logic aFromAlu;
    logic useM;
    logic pcLoad;

    assign addressM = aVal[hackMemMapPkg::addrW-1:0]; // A drops its top bit
    assign outM = aluOut;

    hackControl control0 (.instr(instr), .zr(zr), .ng(ng), .aLoad(aLoad), .dLoad(dLoad),
        .aFromAlu(aFromAlu), .useM(useM), .aluCtl(aluCtl), .writeM(writeM), .pcLoad(pcLoad));

    hackAlu alu0 (.x(dVal), .y(y), .aluCtl(aluCtl), .aluOut(aluOut), .zr(zr), .ng(ng));

    hackRegisters regs0 (.clk(clk), .rstN(rstN), .instr(instr), .aluOut(aluOut),
        .inM(inM), .aLoad(aLoad), .dLoad(dLoad), .aFromAlu(aFromAlu), .useM(useM),
        .aVal(aVal), .dVal(dVal), .y(y));

    hackPc pc0 (.clk(clk), .rstN(rstN), .pcLoad(pcLoad),
        .target(aVal[hackMemMapPkg::pcW-1:0]), .pc(pc)); // Jump to A

    hackMemory mem0 (.clk(clk), .writeM(writeM), .addressM(addressM), .outM(aluOut),
        .inM(inM), .kbd(kbd), .scrAddr(scrAddr), .scrData(scrData));

    hackRom rom0 (.clk(clk), .pc(pc), .instr(instr), .progWe(progWe),
        .progAddr(progAddr), .progData(progData));

endmodule

`default_nettype wire

// ==== src/hackRom.sv ====
// 32K-word instruction ROM with combinational fetch and synchronous program load port
`timescale 1ns/1ps
`default_nettype none

module hackRom (
    input  wire                           clk,
    input  wire [hackMemMapPkg::pcW-1:0]  pc,
    output logic [hackIsaPkg::wordW-1:0]  instr,
    input  wire                           progWe,   // Load strobe, one word per edge
    input  wire [hackMemMapPkg::pcW-1:0]  progAddr,
    input  wire [hackIsaPkg::wordW-1:0]   progData
);

    logic [hackIsaPkg::wordW-1:0] rom [0:(2**hackMemMapPkg::pcW)-1];

    // Power-up image is @0 everywhere, so an unloaded word never writes memory
    initial begin
        for (int i = 0; i < 2**hackMemMapPkg::pcW; i++) begin
            rom[i] = '0;
        end
    end

    // Loader port, used while the CPU sits in reset
    always_ff @(posedge clk) begin
        if (progWe) begin
            rom[progAddr] <= progData;
        end
    end

    assign instr = rom[pc]; // Fetch in the same cycle

endmodule

`default_nettype wire

// ==== src/hackMemory.sv ====
// Data memory: 16K RAM, 8K screen with display read port, keyboard word, address decode
`timescale 1ns/1ps
`default_nettype none

module hackMemory (
    input  wire                              clk,
    input  wire                              writeM,
    input  wire [hackMemMapPkg::addrW-1:0]   addressM,
    input  wire [hackIsaPkg::wordW-1:0]      outM,    // Write data from ALU
    output logic [hackIsaPkg::wordW-1:0]     inM,     // Read data to CPU
    input  wire [hackIsaPkg::wordW-1:0]      kbd,     // Current key code
    input  wire [hackMemMapPkg::screenW-1:0] scrAddr, // Display fetch address
    output logic [hackIsaPkg::wordW-1:0]     scrData
);

    logic [hackIsaPkg::wordW-1:0] ram [0:(2**hackMemMapPkg::ramW)-1];
    logic [hackIsaPkg::wordW-1:0] screen [0:(2**hackMemMapPkg::screenW)-1];

    logic selRam; // 0x0000 to 0x3FFF
    logic selScr; // 0x4000 to 0x5FFF
    logic [hackMemMapPkg::ramW-1:0]    ramIdx;
    logic [hackMemMapPkg::screenW-1:0] scrIdx; // Offset from screenBase

    // Bit 14 splits RAM off, bit 13 splits screen from keyboard
    assign selRam = ~addressM[hackMemMapPkg::ramW];
    assign selScr = addressM[hackMemMapPkg::ramW] & ~addressM[hackMemMapPkg::screenW];
    assign ramIdx = addressM[hackMemMapPkg::ramW-1:0];
    assign scrIdx = addressM[hackMemMapPkg::screenW-1:0];

    // Keyboard region has no storage so writes there drop
    always_ff @(posedge clk) begin
        if (writeM && selRam) begin
            ram[ramIdx] <= outM;
        end
        if (writeM && selScr) begin
            screen[scrIdx] <= outM;
        end
    end

    // CPU read, same cycle as the address
    always_comb begin
        if (selRam) begin
            inM = ram[ramIdx];
        end else if (selScr) begin
            inM = screen[scrIdx];
        end else begin
            inM = kbd; // Read-only keyboard word
        end
    end

    assign scrData = screen[scrAddr]; // Second port for the display

endmodule

`default_nettype wire

// ==== src/hackPc.sv ====
// Program counter with asynchronous clear, jump load and wrapping increment
`timescale 1ns/1ps
`default_nettype none

module hackPc (
    input  wire                            clk,
    input  wire                            rstN,
    input  wire                            pcLoad, // Jump taken
    input  wire [hackMemMapPkg::pcW-1:0]   target, // Low bits of A
    output logic [hackMemMapPkg::pcW-1:0]  pc
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0; // Fetch starts at ROM word 0
        end else if (pcLoad) begin
            pc <= target;
        end else begin
            pc <= pc + 1'b1; // Wraps at 32K
        end
    end

endmodule

`default_nettype wire

// ==== src/hackRegisters.sv ====
// A and D registers with the A input mux and the ALU y operand mux
`timescale 1ns/1ps
`default_nettype none

module hackRegisters (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire [hackIsaPkg::wordW-1:0]  instr,  // Constant for @value
    input  wire [hackIsaPkg::wordW-1:0]  aluOut,
    input  wire [hackIsaPkg::wordW-1:0]  inM,    // Memory read at A
    input  wire                          aLoad,
    input  wire                          dLoad,
    input  wire                          aFromAlu,
    input  wire                          useM,
    output logic [hackIsaPkg::wordW-1:0] aVal,
    output logic [hackIsaPkg::wordW-1:0] dVal,
    output logic [hackIsaPkg::wordW-1:0] y      // Second ALU operand
);

    logic [hackIsaPkg::wordW-1:0] aIn; // Next A value

    assign aIn = aFromAlu ? aluOut : instr; // C dest A, else @value

    // Address register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aVal <= '0;
        end else if (aLoad) begin
            aVal <= aIn;
        end
    end

    // Data register, only ever loaded from the ALU
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dVal <= '0;
        end else if (dLoad) begin
            dVal <= aluOut;
        end
    end

    assign y = useM ? inM : aVal; // The a bit picks M

endmodule

`default_nettype wire

// ==== src/hackAlu.sv ====
// Hack ALU with zx nx zy ny f no controls and zero and negative flags
`timescale 1ns/1ps
`default_nettype none

module hackAlu (
    input  wire [hackIsaPkg::wordW-1:0]  x,      // D register
    input  wire [hackIsaPkg::wordW-1:0]  y,      // A or M
    input  wire [hackIsaPkg::compW-1:0]  aluCtl, // Comp field bits
    output logic [hackIsaPkg::wordW-1:0] aluOut,
    output logic                         zr,
    output logic                         ng
);

    logic [hackIsaPkg::wordW-1:0] xz; // x after zero
    logic [hackIsaPkg::wordW-1:0] xn; // x after negate
    logic [hackIsaPkg::wordW-1:0] yz;
    logic [hackIsaPkg::wordW-1:0] yn;
    logic [hackIsaPkg::wordW-1:0] fOut; // Sum or bitwise and

    always_comb begin
        xz = aluCtl[hackIsaPkg::ctlZx] ? '0 : x;
        xn = aluCtl[hackIsaPkg::ctlNx] ? ~xz : xz;
        yz = aluCtl[hackIsaPkg::ctlZy] ? '0 : y;
        yn = aluCtl[hackIsaPkg::ctlNy] ? ~yz : yz;
        // 16-bit add wraps, carry dropped
        fOut = aluCtl[hackIsaPkg::ctlF] ? (xn + yn) : (xn & yn);
        aluOut = aluCtl[hackIsaPkg::ctlNo] ? ~fOut : fOut;
    end

    assign zr = (aluOut == '0);
    assign ng = aluOut[hackIsaPkg::wordW-1]; // Two's complement sign

endmodule

`default_nettype wire

// ==== src/hackControl.sv ====
// Hack instruction decoder: register loads, operand select, ALU controls, memory write, jump
`timescale 1ns/1ps
`default_nettype none

module hackControl (
    input  wire [hackIsaPkg::wordW-1:0] instr, // Current instruction
    input  wire                         zr,    // ALU result is zero
    input  wire                         ng,    // ALU result is negative
    output logic                        aLoad,
    output logic                        dLoad,
    output logic                        aFromAlu, // A takes aluOut, not instr
    output logic                        useM,     // y is inM
    output logic [hackIsaPkg::compW-1:0] aluCtl,  // zx nx zy ny f no
    output logic                        writeM,
    output logic                        pcLoad
);

    logic isC;       // C-instruction flag
    logic gt;        // Result strictly positive
    logic jumpTaken; // Jump condition met

    assign isC = instr[hackIsaPkg::cBit];

    // Destinations only count on C-instructions
    assign aFromAlu = isC & instr[hackIsaPkg::destA];
    assign aLoad    = ~isC | aFromAlu; // @value, or A in dest
    assign dLoad    = isC & instr[hackIsaPkg::destD];
    assign writeM   = isC & instr[hackIsaPkg::destM];
    assign useM     = isC & instr[hackIsaPkg::aBit];

    // A-instruction bits would look like random ALU controls
    assign aluCtl = isC ? instr[hackIsaPkg::compHi:hackIsaPkg::compLo] : '0;

    // Jump logic on the ALU flags
    assign gt = ~(ng | zr);
    assign jumpTaken = (instr[hackIsaPkg::jmpLt] & ng) |
                       (instr[hackIsaPkg::jmpEq] & zr) |
                       (instr[hackIsaPkg::jmpGt] & gt);
    assign pcLoad = isC & jumpTaken; // Never jump on @value

endmodule

`default_nettype wire

// ==== src/hackMemMapPkg.sv ====
// Memory-map localparams: address widths, RAM and screen sizes, screen and keyboard addresses
`default_nettype none

package hackMemMapPkg;

    // Address widths
    localparam int addrW   = 15; // Data address from A
    localparam int pcW     = 15; // Instruction address
    localparam int ramW    = 14; // 16K data RAM
    localparam int screenW = 13; // 8K screen words

    // Region bases
    localparam int screenBase = 16384; // 0x4000, bit 14 set
    localparam int kbdAddr    = 24576; // 0x6000, bits 14 and 13 set

endpackage

`default_nettype wire

// ==== src/hackIsaPkg.sv ====
// Instruction-format localparams: word width, field bit positions, ALU control bits
`default_nettype none

package hackIsaPkg;

    // Word size shared by data and instructions
    localparam int wordW = 16;

    // Instruction type
    localparam int cBit = 15; // Set on C-instructions
    localparam int aBit = 12; // Operand is M instead of A

    // Comp field, six ALU controls
    localparam int compHi = 11; // zx sits here
    localparam int compLo = 6;  // no sits here
    localparam int compW  = compHi - compLo + 1;

    // Control bit order inside the comp field
    localparam int ctlZx = 5; // Zero x
    localparam int ctlNx = 4; // Negate x
    localparam int ctlZy = 3; // Zero y
    localparam int ctlNy = 2; // Negate y
    localparam int ctlF  = 1; // Add when set, and when clear
    localparam int ctlNo = 0; // Negate result

    // Destination bits
    localparam int destA = 5;
    localparam int destD = 4;
    localparam int destM = 3;

    // Jump bits, compared against the ALU result sign
    localparam int jmpLt = 2;
    localparam int jmpEq = 1;
    localparam int jmpGt = 0;

endpackage

`default_nettype wire
